// ==== include/eu_consts.svh ====
`ifndef EU_CONSTS_SVH
`define EU_CONSTS_SVH

////////////////////////////////////////////////////////////
// SDRAM side
////////////////////////////////////////////////////////////

// Data word width of the SDRAM read port
`define EU_SDRAM_W 32

// Word address width
`define EU_ADDR_W 24

////////////////////////////////////////////////////////////
// Execution units
////////////////////////////////////////////////////////////

// Words loaded into a unit buffer by one fetch
`define EU_FETCH_DEPTH 8

// One stmm unit and one layernorm unit
`define EU_NUM_UNITS 2

`endif

// ==== sim/eu_tb.sv ====
`default_nettype none

`include "eu_consts.svh"

module eu_tb
    import sdram_pkg::*, eu_pkg::*;
;

// About 100 cycles for each of up to 8 tests
localparam int TIMEOUT_CYCLES = 8 * 100;
localparam int RANDOM_CMDS    = 10;

logic                               clk;
logic                               rst_n;
logic                               cmd_valid;
eu_cmd_t                            cmd;
logic                               cmd_ready;
wb_rd_req_t                         wb_req;
wb_rd_rsp_t                         wb_rsp;
logic [`EU_NUM_UNITS-1:0]           fetch_done;
logic [`EU_NUM_UNITS-1:0]           exec_done;
logic [31:0]                        result;
logic                               result_valid;
eu_unit_e                           result_unit;

integer                             seed = 32'h6dc6_616c;
int                                 errors = 0;
int                                 commands = 0;
int                                 cycles = 0;

// Slave state and the addresses it has acked
logic                               pending;
int                                 wait_cnt;
logic [`EU_ADDR_W-1:0]              bus_log[$];

// Expected buffer contents of both units
logic [31:0]                        stmm_mem [`EU_FETCH_DEPTH];
logic [31:0]                        ln_mem [`EU_FETCH_DEPTH];

eu_top dut_i (
    .clk            (clk),
    .i_rst_n        (rst_n),
    .i_cmd_valid    (cmd_valid),
    .i_cmd          (cmd),
    .o_cmd_ready    (cmd_ready),
    .o_wb_req       (wb_req),
    .i_wb_rsp       (wb_rsp),
    .o_fetch_done   (fetch_done),
    .o_exec_done    (exec_done),
    .o_result       (result),
    .o_result_valid (result_valid),
    .o_result_unit  (result_unit)
);

initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
end

////////////////////////////////////////////////////////////
// SDRAM slave model
////////////////////////////////////////////////////////////

function automatic logic [31:0] sdram_word(input logic [`EU_ADDR_W-1:0] adr);
    logic [31:0] a;
    a = 32'(adr);
    return a * 32'h0001_0003 + 32'h0102_0304;
endfunction

always @(posedge clk) begin
    if (!rst_n) begin
        wb_rsp  <= '0;
        pending = 1'b0;
    end else if (wb_rsp.ack) begin
        // Word is taken on this edge
        wb_rsp  <= '0;
        pending = 1'b0;
    end else if (wb_req.cyc && wb_req.stb) begin
        if (!pending) begin
            pending  = 1'b1;
            wait_cnt = $random(seed) & 32'h3;
        end
        if (wait_cnt == 0) begin
            wb_rsp.ack <= 1'b1;
            wb_rsp.dat <= sdram_word(wb_req.adr);
            bus_log.push_back(wb_req.adr);
        end else begin
            wait_cnt = wait_cnt - 1;
        end
    end
end

always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
        $display("timeout, run stopped after %0d cycles", cycles);
        $display("%0d commands, %0d errors", commands, errors);
        $display("** FAIL **");
        $finish;
    end
end

////////////////////////////////////////////////////////////
// Expected results
////////////////////////////////////////////////////////////

function automatic logic [31:0] expect_dot(input logic [31:0] act);
    logic signed [7:0] w;
    logic signed [7:0] a;
    int                sum;
    sum = 0;
    for (int k = 0; k < `EU_FETCH_DEPTH; k++) begin
        for (int l = 0; l < 4; l++) begin
            w   = stmm_mem[k][8*l +: 8];
            a   = act[8*l +: 8];
            sum = sum + w * a;
        end
    end
    return sum;
endfunction

function automatic logic [31:0] expect_ln(input logic [31:0] arg);
    logic [31:0]        word;
    logic signed [15:0] gamma;
    logic signed [15:0] beta;
    logic signed [15:0] x;
    int                 prod;
    word  = ln_mem[arg[18:16]];
    gamma = word[31:16];
    beta  = word[15:0];
    x     = arg[15:0];
    prod  = gamma * x;
    return (prod >>> 8) + beta;
endfunction

task automatic load_model(input eu_unit_e unit, input logic [`EU_ADDR_W-1:0] addr);
    logic [`EU_ADDR_W-1:0] adr;
    for (int k = 0; k < `EU_FETCH_DEPTH; k++) begin
        adr = addr + k;
        if (unit == UNIT_STMM) begin
            stmm_mem[k] = sdram_word(adr);
        end else begin
            ln_mem[k] = sdram_word(adr);
        end
    end
endtask

task automatic log_mismatch(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    errors++;
    $display("mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
endtask

task automatic fail_check(input string what);
    errors++;
    $display("error at %0t: %s", $time, what);
endtask

////////////////////////////////////////////////////////////
// Command helpers
////////////////////////////////////////////////////////////

// Returns on the edge that accepts the command
task automatic send_cmd(input eu_op_e op, input eu_unit_e unit,
                        input logic [`EU_ADDR_W-1:0] addr, input logic [31:0] arg);
    eu_cmd_t c;
    c.op   = op;
    c.unit = unit;
    c.addr = addr;
    c.arg  = arg;
    @(posedge clk);
    cmd_valid <= 1'b1;
    cmd       <= c;
    do @(negedge clk); while (!cmd_ready);
    @(posedge clk);
    cmd_valid <= 1'b0;
    commands++;
endtask

// Sticky bit first drops on the new start, then rises at the end
task automatic await_fetch_done(input eu_unit_e unit);
    do @(negedge clk); while (fetch_done[unit]);
    do @(negedge clk); while (!fetch_done[unit]);
endtask

task automatic wait_result();
    do @(negedge clk); while (!result_valid);
endtask

task automatic check_result(input eu_unit_e unit, input logic [31:0] exp);
    wait_result();
    if (result !== exp) log_mismatch("o_result", result, exp);
    if (result_unit !== unit) log_mismatch("o_result_unit", result_unit, unit);
    if (exec_done[unit] !== 1'b1) fail_check("exec done bit not set for the finishing unit");
endtask

task automatic fetch_and_check(input eu_unit_e unit, input logic [`EU_ADDR_W-1:0] addr);
    logic [`EU_ADDR_W-1:0] exp_adr;
    bus_log.delete();
    send_cmd(OP_FETCH, unit, addr, 32'h0);
    await_fetch_done(unit);
    if (bus_log.size() != `EU_FETCH_DEPTH) begin
        log_mismatch("bus read count", bus_log.size(), `EU_FETCH_DEPTH);
    end else begin
        for (int k = 0; k < `EU_FETCH_DEPTH; k++) begin
            exp_adr = addr + k;
            if (bus_log[k] !== exp_adr) log_mismatch("o_wb_req.adr", bus_log[k], exp_adr);
        end
    end
    load_model(unit, addr);
endtask

task automatic exec_and_check(input eu_unit_e unit, input logic [31:0] arg);
    logic [31:0] exp;
    exp = (unit == UNIT_STMM) ? expect_dot(arg) : expect_ln(arg);
    send_cmd(OP_EXEC, unit, '0, arg);
    check_result(unit, exp);
endtask

////////////////////////////////////////////////////////////
// Directed tests
////////////////////////////////////////////////////////////

task automatic check_after_reset();
    @(negedge clk);
    if (cmd_ready !== 1'b1) fail_check("command input not ready after reset");
    if (fetch_done !== '0) log_mismatch("o_fetch_done", fetch_done, 0);
    if (exec_done !== '0) log_mismatch("o_exec_done", exec_done, 0);
    // Empty buffers give zero
    send_cmd(OP_EXEC, UNIT_STMM, '0, 32'h7f80_01ff);
    check_result(UNIT_STMM, 32'h0);
    send_cmd(OP_EXEC, UNIT_LAYERNORM, '0, 32'h0003_8000);
    check_result(UNIT_LAYERNORM, 32'h0);
endtask

task automatic stmm_fetch_seq();
    fetch_and_check(UNIT_STMM, 24'h00_1230);
    if (fetch_done !== 2'b01) log_mismatch("o_fetch_done", fetch_done, 2'b01);
endtask

task automatic stmm_dot_product();
    exec_and_check(UNIT_STMM, 32'h807f_ff05);
    exec_and_check(UNIT_STMM, 32'h01fe_40c3);
endtask

task automatic layernorm_affine();
    fetch_and_check(UNIT_LAYERNORM, 24'h0a_bc00);
    exec_and_check(UNIT_LAYERNORM, {13'h0, 3'd0, 16'h0100});
    exec_and_check(UNIT_LAYERNORM, {13'h0, 3'd3, 16'hff00});
    exec_and_check(UNIT_LAYERNORM, {13'h0, 3'd7, 16'h8000});
    exec_and_check(UNIT_LAYERNORM, {13'h0, 3'd5, 16'h7fff});
    exec_and_check(UNIT_LAYERNORM, {13'h0, 3'd2, 16'hfffd});
endtask

task automatic busy_hold_off();
    logic [31:0] arg2;
    eu_cmd_t     c2;
    int          held;
    arg2    = {13'h0, 3'd4, 16'hfb2e};
    c2.op   = OP_EXEC;
    c2.unit = UNIT_LAYERNORM;
    c2.addr = '0;
    c2.arg  = arg2;
    send_cmd(OP_FETCH, UNIT_STMM, 24'h00_4000, 32'h0);
    // Second command waits at the input
    cmd_valid <= 1'b1;
    cmd       <= c2;
    held = 0;
    @(negedge clk);
    while (!cmd_ready) begin
        held++;
        if (held > 1 && fetch_done[0] !== 1'b0) begin
            fail_check("fetch done bit 0 still set while a new fetch runs");
        end
        @(negedge clk);
    end
    if (fetch_done[0] !== 1'b1) fail_check("second command taken before the fetch ended");
    if (held < `EU_FETCH_DEPTH) fail_check("second command was not held off");
    @(posedge clk);
    cmd_valid <= 1'b0;
    commands++;
    load_model(UNIT_STMM, 24'h00_4000);
    check_result(UNIT_LAYERNORM, expect_ln(arg2));
endtask

task automatic random_mix();
    logic [31:0] r;
    logic [31:0] arg;
    eu_unit_e    unit;
    for (int n = 0; n < RANDOM_CMDS; n++) begin
        r    = $random(seed);
        unit = eu_unit_e'(r[0]);
        if (r[1]) begin
            fetch_and_check(unit, r[31:8]);
        end else begin
            arg = $random(seed);
            exec_and_check(unit, arg);
        end
    end
endtask

initial begin
    rst_n     = 1'b0;
    cmd_valid = 1'b0;
    cmd       = '0;
    wb_rsp    = '0;
    for (int k = 0; k < `EU_FETCH_DEPTH; k++) begin
        stmm_mem[k] = '0;
        ln_mem[k]   = '0;
    end
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;

    check_after_reset();
    stmm_fetch_seq();
    stmm_dot_product();
    layernorm_affine();
    busy_hold_off();
    random_mix();

    $display("%0d commands, %0d errors", commands, errors);
    if (errors == 0) begin
        $display("** PASS **");
    end else begin
        $display("** FAIL **");
    end
    $finish;
end

endmodule

`default_nettype wire

// ==== source/eu_cmd_decode.sv ====
`default_nettype none

`include "eu_consts.svh"

module eu_cmd_decode
    import eu_pkg::*;
(
    input  wire                                clk,
    input  wire                                i_rst_n,

    // Command from the control unit
    input  wire                                i_cmd_valid,
    input  wire  eu_cmd_t                      i_cmd,
    output logic                               o_cmd_ready,

    output eu_start_t                          o_start_stmm,
    output eu_start_t                          o_start_ln,
    output logic [$clog2(`EU_NUM_UNITS)-1:0]   o_sel,

    input  wire  eu_unit_res_t                 i_res_stmm,
    input  wire  eu_unit_res_t                 i_res_ln
);

localparam int SEL_W = $clog2(`EU_NUM_UNITS);

logic         busy;
logic         issue;
logic         accept;
logic         unit_done;
eu_cmd_t      cmd_q;
eu_unit_res_t res_sel;
eu_start_t    start_pl;

assign o_cmd_ready = !busy;
assign accept      = i_cmd_valid && o_cmd_ready;

// Only the unit that owns the command can release us
assign res_sel   = (cmd_q.unit == UNIT_STMM) ? i_res_stmm : i_res_ln;
assign unit_done = res_sel.fetch_done || res_sel.exec_done;

always_ff @(posedge clk) begin
    if (!i_rst_n) begin
        busy  <= 1'b0;
        issue <= 1'b0;
        o_sel <= '0;
    end else begin
        issue <= accept;
        if (accept) begin
            busy  <= 1'b1;
            o_sel <= SEL_W'(i_cmd.unit);
        end else if (busy && unit_done) begin
            busy <= 1'b0;
        end
    end
end

always_ff @(posedge clk) begin
    if (accept) begin
        cmd_q <= i_cmd;
    end
end

////////////////////////////////////////////////////////////
// Start pulses, one cycle after acceptance
////////////////////////////////////////////////////////////

always_comb begin
    start_pl.fetch = issue && (cmd_q.op == OP_FETCH);
    start_pl.exec  = issue && (cmd_q.op == OP_EXEC);
    start_pl.addr  = cmd_q.addr;
    start_pl.arg   = cmd_q.arg;

    o_start_stmm = start_pl;
    o_start_ln   = start_pl;
    if (cmd_q.unit == UNIT_STMM) begin
        o_start_ln.fetch = 1'b0;
        o_start_ln.exec  = 1'b0;
    end else begin
        o_start_stmm.fetch = 1'b0;
        o_start_stmm.exec  = 1'b0;
    end
end

// A unit only finishes while its command is still held here
a_done_busy: assert property (@(posedge clk) disable iff (!i_rst_n)
    (i_res_stmm.fetch_done || i_res_stmm.exec_done ||
     i_res_ln.fetch_done || i_res_ln.exec_done) |-> busy);

endmodule

`default_nettype wire

// ==== source/eu_pkg.sv ====
`include "eu_consts.svh"

package eu_pkg;

    ////////////////////////////////////////////////////////////
    // Commands from the control unit
    ////////////////////////////////////////////////////////////

    typedef enum logic {
        UNIT_STMM      = 1'b0,
        UNIT_LAYERNORM = 1'b1
    } eu_unit_e;

    typedef enum logic {
        OP_FETCH = 1'b0,
        OP_EXEC  = 1'b1
    } eu_op_e;

    typedef struct packed {
        eu_op_e                op;
        eu_unit_e              unit;
        logic [`EU_ADDR_W-1:0] addr;
        logic [31:0]           arg;
    } eu_cmd_t;

    // Start pulse and operands for one unit
    typedef struct packed {
        logic                  fetch;
        logic                  exec;
        logic [`EU_ADDR_W-1:0] addr;
        logic [31:0]           arg;
    } eu_start_t;

    // Done pulses last one cycle
    typedef struct packed {
        logic        fetch_done;
        logic        exec_done;
        logic [31:0] result;
    } eu_unit_res_t;

    ////////////////////////////////////////////////////////////
    // Buffer entries
    ////////////////////////////////////////////////////////////

    // Four int8 weights, lane 0 in bits 7:0
    typedef struct packed {
        logic [3:0][7:0] lane;
    } stmm_entry_t;

    typedef struct packed {
        logic signed [15:0] gamma;
        logic signed [15:0] beta;
    } ln_entry_t;

endpackage

// ==== source/eu_result.sv ====
`default_nettype none

`include "eu_consts.svh"

module eu_result
    import eu_pkg::*;
(
    input  wire                         clk,
    input  wire                         i_rst_n,

    input  wire  eu_start_t             i_start_stmm,
    input  wire  eu_start_t             i_start_ln,
    input  wire  eu_unit_res_t          i_res_stmm,
    input  wire  eu_unit_res_t          i_res_ln,

    output logic [`EU_NUM_UNITS-1:0]    o_fetch_done,
    output logic [`EU_NUM_UNITS-1:0]    o_exec_done,

    output logic [31:0]                 o_result,
    output logic                        o_result_valid,
    output eu_unit_e                    o_result_unit
);

// Index 0 is stmm, 1 is layernorm
eu_start_t    [`EU_NUM_UNITS-1:0] starts;
eu_unit_res_t [`EU_NUM_UNITS-1:0] res;
logic         [`EU_NUM_UNITS-1:0] exec_pulse;

assign starts = {i_start_ln, i_start_stmm};
assign res    = {i_res_ln, i_res_stmm};

always_comb begin
    for (int u = 0; u < `EU_NUM_UNITS; u++) begin
        exec_pulse[u] = res[u].exec_done;
    end
end

////////////////////////////////////////////////////////////
// Sticky status
////////////////////////////////////////////////////////////

always_ff @(posedge clk) begin
    if (!i_rst_n) begin
        o_fetch_done <= '0;
        o_exec_done  <= '0;
    end else begin
        for (int u = 0; u < `EU_NUM_UNITS; u++) begin
            if (starts[u].fetch) begin
                o_fetch_done[u] <= 1'b0;
            end else if (res[u].fetch_done) begin
                o_fetch_done[u] <= 1'b1;
            end
            if (starts[u].exec) begin
                o_exec_done[u] <= 1'b0;
            end else if (res[u].exec_done) begin
                o_exec_done[u] <= 1'b1;
            end
        end
    end
end

////////////////////////////////////////////////////////////
// Result capture
////////////////////////////////////////////////////////////

always_ff @(posedge clk) begin
    if (!i_rst_n) begin
        o_result_valid <= 1'b0;
    end else begin
        o_result_valid <= |exec_pulse;
    end
end

always_ff @(posedge clk) begin
    for (int u = 0; u < `EU_NUM_UNITS; u++) begin
        if (exec_pulse[u]) begin
            o_result      <= res[u].result;
            o_result_unit <= eu_unit_e'(u);
        end
    end
end

// Status and result must agree on the unit that finished
a_result_status: assert property (@(posedge clk) disable iff (!i_rst_n)
    o_result_valid |-> o_exec_done[o_result_unit]);

endmodule

`default_nettype wire

// ==== source/eu_top.sv ====
`default_nettype none

`include "eu_consts.svh"

module eu_top
    import sdram_pkg::*, eu_pkg::*;
(
    input  wire                         clk,
    input  wire                         i_rst_n,

    // Control unit commands
    input  wire                         i_cmd_valid,
    input  wire  eu_cmd_t               i_cmd,
    output logic                        o_cmd_ready,

    // SDRAM read port
    output wb_rd_req_t                  o_wb_req,
    input  wire  wb_rd_rsp_t            i_wb_rsp,

    // Status back to the control unit
    output logic [`EU_NUM_UNITS-1:0]    o_fetch_done,
    output logic [`EU_NUM_UNITS-1:0]    o_exec_done,
    output logic [31:0]                 o_result,
    output logic                        o_result_valid,
    output eu_unit_e                    o_result_unit
);

eu_start_t                          start_stmm;
eu_start_t                          start_ln;
eu_unit_res_t                       res_stmm;
eu_unit_res_t                       res_ln;
logic [$clog2(`EU_NUM_UNITS)-1:0]   sel;
wb_rd_req_t [`EU_NUM_UNITS-1:0]     unit_req;
wb_rd_rsp_t [`EU_NUM_UNITS-1:0]     unit_rsp;

////////////////////////////////////////////////////////////
// Command path
////////////////////////////////////////////////////////////

eu_cmd_decode i_eu_cmd_decode (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .i_cmd_valid  (i_cmd_valid),
    .i_cmd        (i_cmd),
    .o_cmd_ready  (o_cmd_ready),
    .o_start_stmm (start_stmm),
    .o_start_ln   (start_ln),
    .o_sel        (sel),
    .i_res_stmm   (res_stmm),
    .i_res_ln     (res_ln)
);

////////////////////////////////////////////////////////////
// Execution units
////////////////////////////////////////////////////////////

stmm_unit i_stmm_unit (
    .clk      (clk),
    .i_rst_n  (i_rst_n),
    .i_start  (start_stmm),
    .o_wb_req (unit_req[UNIT_STMM]),
    .i_wb_rsp (unit_rsp[UNIT_STMM]),
    .o_res    (res_stmm)
);

layernorm_unit i_layernorm_unit (
    .clk      (clk),
    .i_rst_n  (i_rst_n),
    .i_start  (start_ln),
    .o_wb_req (unit_req[UNIT_LAYERNORM]),
    .i_wb_rsp (unit_rsp[UNIT_LAYERNORM]),
    .o_res    (res_ln)
);

sdram_read_mux #(
    .NUM_PORTS (`EU_NUM_UNITS)
) i_sdram_read_mux (
    .clk      (clk),
    .i_rst_n  (i_rst_n),
    .i_sel    (sel),
    .i_req    (unit_req),
    .o_rsp    (unit_rsp),
    .o_wb_req (o_wb_req),
    .i_wb_rsp (i_wb_rsp)
);

eu_result i_eu_result (
    .clk            (clk),
    .i_rst_n        (i_rst_n),
    .i_start_stmm   (start_stmm),
    .i_start_ln     (start_ln),
    .i_res_stmm     (res_stmm),
    .i_res_ln       (res_ln),
    .o_fetch_done   (o_fetch_done),
    .o_exec_done    (o_exec_done),
    .o_result       (o_result),
    .o_result_valid (o_result_valid),
    .o_result_unit  (o_result_unit)
);

endmodule

`default_nettype wire

// ==== source/fetch_buffer.sv ====
`default_nettype none

`include "eu_consts.svh"

module fetch_buffer
    import sdram_pkg::*;
#(
    parameter type T_ENTRY = logic [`EU_SDRAM_W-1:0]
) (
    input  wire                                clk,
    input  wire                                i_rst_n,

    // Fetch request
    input  wire                                i_start,
    input  wire  [`EU_ADDR_W-1:0]              i_addr,

    // Wishbone master
    output wb_rd_req_t                         o_wb_req,
    input  wire  wb_rd_rsp_t                   i_wb_rsp,

    // Local read port
    input  wire  [$clog2(`EU_FETCH_DEPTH)-1:0] i_rd_idx,
    output T_ENTRY                             o_rd_entry,

    output logic                               o_done
);

localparam int IDX_W = $clog2(`EU_FETCH_DEPTH);
localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(`EU_FETCH_DEPTH - 1);

logic                  busy;
logic [IDX_W-1:0]      cnt;
logic [`EU_ADDR_W-1:0] adr;
logic                  word_ack;

T_ENTRY mem [`EU_FETCH_DEPTH];

// One word lands per ack
assign word_ack = busy && i_wb_rsp.ack;

////////////////////////////////////////////////////////////
// Read sequencer
////////////////////////////////////////////////////////////

always_ff @(posedge clk) begin
    if (!i_rst_n) begin
        busy   <= 1'b0;
        cnt    <= '0;
        adr    <= '0;
        o_done <= 1'b0;
    end else begin
        o_done <= 1'b0;
        if (!busy && i_start) begin
            busy <= 1'b1;
            cnt  <= '0;
            adr  <= i_addr;
        end else if (word_ack) begin
            // stb stays up for the next address
            adr <= adr + 1'b1;
            cnt <= cnt + 1'b1;
            if (cnt == LAST_IDX) begin
                busy   <= 1'b0;
                o_done <= 1'b1;
            end
        end
    end
end

assign o_wb_req.cyc = busy;
assign o_wb_req.stb = busy;
assign o_wb_req.adr = adr;

////////////////////////////////////////////////////////////
// Storage
////////////////////////////////////////////////////////////

always_ff @(posedge clk) begin
    if (!i_rst_n) begin
        for (int i = 0; i < `EU_FETCH_DEPTH; i++) begin
            mem[i] <= '0;
        end
    end else if (word_ack) begin
        mem[cnt] <= T_ENTRY'(i_wb_rsp.dat);
    end
end

assign o_rd_entry = mem[i_rd_idx];

// Classic cycle: an ack only ever answers a live strobe of this master
a_ack_with_stb: assert property (@(posedge clk) disable iff (!i_rst_n)
    i_wb_rsp.ack |-> o_wb_req.stb);

endmodule

`default_nettype wire

// ==== source/layernorm_unit.sv ====
`default_nettype none

`include "eu_consts.svh"

module layernorm_unit
    import sdram_pkg::*, eu_pkg::*;
(
    input  wire                clk,
    input  wire                i_rst_n,

    input  wire  eu_start_t    i_start,

    output wb_rd_req_t         o_wb_req,
    input  wire  wb_rd_rsp_t   i_wb_rsp,

    output eu_unit_res_t       o_res
);

localparam int IDX_W = $clog2(`EU_FETCH_DEPTH);

logic               fetch_done;
logic               mul_vld;
logic               exec_done;
logic signed [15:0] x;
logic signed [31:0] prod_q;
logic signed [15:0] beta_q;
logic signed [31:0] res_q;
ln_entry_t          entry;

// x in arg[15:0], entry index just above it
assign x = $signed(i_start.arg[15:0]);

fetch_buffer #(
    .T_ENTRY (ln_entry_t)
) i_fetch_buffer (
    .clk        (clk),
    .i_rst_n    (i_rst_n),
    .i_start    (i_start.fetch),
    .i_addr     (i_start.addr),
    .o_wb_req   (o_wb_req),
    .i_wb_rsp   (i_wb_rsp),
    .i_rd_idx   (i_start.arg[16 +: IDX_W]),
    .o_rd_entry (entry),
    .o_done     (fetch_done)
);

////////////////////////////////////////////////////////////
// Scale, then shift
////////////////////////////////////////////////////////////

always_ff @(posedge clk) begin
    if (!i_rst_n) begin
        mul_vld   <= 1'b0;
        exec_done <= 1'b0;
    end else begin
        mul_vld   <= i_start.exec;
        exec_done <= mul_vld;
    end
end

always_ff @(posedge clk) begin
    if (i_start.exec) begin
        prod_q <= entry.gamma * x;
        beta_q <= entry.beta;
    end
    // Q8 gamma, so drop 8 fraction bits before adding beta
    if (mul_vld) begin
        res_q <= (prod_q >>> 8) + beta_q;
    end
end

assign o_res.fetch_done = fetch_done;
assign o_res.exec_done  = exec_done;
assign o_res.result     = res_q;

endmodule

`default_nettype wire

// ==== source/sdram_pkg.sv ====
`include "eu_consts.svh"

package sdram_pkg;

    ////////////////////////////////////////////////////////////
    // Wishbone classic, read only
    ////////////////////////////////////////////////////////////

    // Master side of a read cycle
    typedef struct packed {
        logic                    cyc;
        logic                    stb;
        logic [`EU_ADDR_W-1:0]   adr;
    } wb_rd_req_t;

    // Slave side, dat is valid in the ack cycle only
    typedef struct packed {
        logic                    ack;
        logic [`EU_SDRAM_W-1:0]  dat;
    } wb_rd_rsp_t;

endpackage

// ==== source/sdram_read_mux.sv ====
`default_nettype none

module sdram_read_mux
    import sdram_pkg::*;
#(
    parameter int NUM_PORTS = 2
) (
    input  wire                                  clk,
    input  wire                                  i_rst_n,

    input  wire  [$clog2(NUM_PORTS)-1:0]         i_sel,

    // Unit side masters
    input  wire  wb_rd_req_t [NUM_PORTS-1:0]     i_req,
    output wb_rd_rsp_t       [NUM_PORTS-1:0]     o_rsp,

    // External SDRAM port
    output wb_rd_req_t                           o_wb_req,
    input  wire  wb_rd_rsp_t                     i_wb_rsp
);

localparam int SEL_W = $clog2(NUM_PORTS);

always_comb begin
    o_wb_req = i_req[i_sel];
    for (int p = 0; p < NUM_PORTS; p++) begin
        o_rsp[p].dat = i_wb_rsp.dat;
        // Unselected masters never see an ack
        o_rsp[p].ack = i_wb_rsp.ack && (i_sel == SEL_W'(p));
    end
end

// Switching mid-cycle would hand the ack to the wrong master
a_sel_stable: assert property (@(posedge clk) disable iff (!i_rst_n)
    o_wb_req.cyc |=> $stable(i_sel));

endmodule

`default_nettype wire

// ==== source/stmm_unit.sv ====
`default_nettype none

`include "eu_consts.svh"

module stmm_unit
    import sdram_pkg::*, eu_pkg::*;
(
    input  wire                clk,
    input  wire                i_rst_n,

    input  wire  eu_start_t    i_start,

    output wb_rd_req_t         o_wb_req,
    input  wire  wb_rd_rsp_t   i_wb_rsp,

    output eu_unit_res_t       o_res
);

localparam int IDX_W = $clog2(`EU_FETCH_DEPTH);
localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(`EU_FETCH_DEPTH - 1);

logic               running;
logic               exec_done;
logic               fetch_done;
logic [IDX_W-1:0]   idx;
logic [3:0][7:0]    act_q;
logic signed [31:0] acc;
logic signed [31:0] dot;
stmm_entry_t        entry;

fetch_buffer #(
    .T_ENTRY (stmm_entry_t)
) i_fetch_buffer (
    .clk        (clk),
    .i_rst_n    (i_rst_n),
    .i_start    (i_start.fetch),
    .i_addr     (i_start.addr),
    .o_wb_req   (o_wb_req),
    .i_wb_rsp   (i_wb_rsp),
    .i_rd_idx   (idx),
    .o_rd_entry (entry),
    .o_done     (fetch_done)
);

////////////////////////////////////////////////////////////
// Dot product, one weight word per cycle
////////////////////////////////////////////////////////////

// Four signed int8 products of the current word
always_comb begin
    dot = '0;
    for (int l = 0; l < 4; l++) begin
        dot = dot + $signed(entry.lane[l]) * $signed(act_q[l]);
    end
end

always_ff @(posedge clk) begin
    if (!i_rst_n) begin
        running   <= 1'b0;
        idx       <= '0;
        exec_done <= 1'b0;
    end else begin
        exec_done <= 1'b0;
        if (i_start.exec) begin
            running <= 1'b1;
            idx     <= '0;
        end else if (running) begin
            idx <= idx + 1'b1;
            if (idx == LAST_IDX) begin
                running   <= 1'b0;
                exec_done <= 1'b1;
            end
        end
    end
end

always_ff @(posedge clk) begin
    if (i_start.exec) begin
        act_q <= i_start.arg;
        acc   <= '0;
    end else if (running) begin
        acc <= acc + dot;
    end
end

assign o_res.fetch_done = fetch_done;
assign o_res.exec_done  = exec_done;
assign o_res.result     = acc;

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+include
source/sdram_pkg.sv
source/eu_pkg.sv
source/fetch_buffer.sv
source/sdram_read_mux.sv
source/eu_cmd_decode.sv
source/stmm_unit.sv
source/layernorm_unit.sv
source/eu_result.sv
source/eu_top.sv
sim/eu_tb.sv
